/* source/mmio_pkg.sv */
package mmio_pkg;

    // one command from the memory handler, held for a single cycle
    typedef struct packed {
        logic        read;
        logic        write;
        logic        getinst;   // instruction fetch, routed like a read
        logic [31:0] address;
        logic [31:0] data;      // write data
    } mh_req_t;

    // strobe/busy request to the data memory
    typedef struct packed {
        logic [31:0] address;
        logic [31:0] data;
        logic        read;
        logic        write;
    } mem_req_t;

    // command frame for the display SPI shifter
    typedef struct packed {
        logic [7:0]  command;
        logic [3:0]  counter;     // parameter bytes after the command, 0 to 4
        logic [31:0] parameters;  // msb byte goes out first
        logic        start;       // one cycle strobe
    } spi_cmd_t;

    typedef enum logic [2:0] {
        IDLE,
        PENDING,   // command latched, waiting for its target
        MEMREAD,
        MEMWRITE,
        DONE
    } mmio_state_t;

    // fixed target addresses, all above the memory window
    localparam logic [31:0] SPI_ADDR_CMD   = 32'd121212; // command byte + counter
    localparam logic [31:0] SPI_ADDR_PARAM = 32'd333333; // parameters, starts the frame
    localparam logic [31:0] I2C_ADDR       = 32'd923923; // touch xy word

endpackage

/* source/touch_latch.sv */
`timescale 1ns/10ps

module touch_latch (
    input  logic        clk,
    input  logic        nRst,
    input  logic [31:0] i2c_xy_i,
    input  logic        i2c_valid_i,
    input  logic        clear_i,
    output logic [31:0] xy_o,
    output logic        done_o
);
    logic [31:0] xy_q;
    logic        done_q;

    assign xy_o   = xy_q;
    assign done_o = done_q;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            xy_q   <= '0;
            done_q <= 1'b0;
        end else if (i2c_valid_i) begin
            // a fresh sample beats a clear in the same cycle
            xy_q   <= i2c_xy_i;
            done_q <= 1'b1;
        end else if (clear_i) begin
            done_q <= 1'b0;
        end
    end

endmodule

/* source/wb_sram.sv */
`timescale 1ns/10ps

module wb_sram #(
    parameter int unsigned MEM_BYTES = 2048,
    parameter int unsigned MEM_WAIT  = 2    // at least 1
) (
    input  logic               clk,
    input  logic               nRst,
    input  mmio_pkg::mem_req_t req_i,
    output logic [31:0]        data_o,
    output logic               busy_o
);
    localparam int unsigned WORDS = MEM_BYTES / 4;
    localparam int unsigned AW    = $clog2(WORDS);
    localparam int unsigned CW    = $clog2(MEM_WAIT + 1);

    logic [31:0]   mem [WORDS];
    logic [31:0]   rdata_q;
    logic [CW-1:0] wait_q;
    logic          ack_q;     // access finished, strobe not yet dropped
    logic          strobe;
    logic          last;
    logic [AW-1:0] idx;

    assign strobe = req_i.read | req_i.write;
    assign idx    = req_i.address[AW+1:2];     // word index
    assign last   = (wait_q == CW'(MEM_WAIT - 1));

    // busy from the first strobe cycle until the wait has run out
    assign busy_o = strobe & ~ack_q;
    assign data_o = rdata_q;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            wait_q  <= '0;
            ack_q   <= 1'b0;
            rdata_q <= '0;
        end else if (!strobe) begin
            wait_q <= '0;
            ack_q  <= 1'b0;
        end else if (!ack_q) begin
            if (last) begin
                wait_q <= '0;
                ack_q  <= 1'b1;
                if (req_i.read) begin
                    rdata_q <= mem[idx];
                end
            end else begin
                wait_q <= wait_q + 1'b1;
            end
        end
    end

    // write lands at the end of the wait
    always_ff @(posedge clk) begin
        if (strobe && !ack_q && last && req_i.write) begin
            mem[idx] <= req_i.data;
        end
    end

endmodule

/* source/spi_cmd_shifter.sv */
`timescale 1ns/10ps

module spi_cmd_shifter #(
    parameter int unsigned SPI_DIV = 4  // clk cycles per sck half period
) (
    input  logic               clk,
    input  logic               nRst,
    input  mmio_pkg::spi_cmd_t cmd_i,
    output logic               busy_o,
    output logic               spi_sck_o,
    output logic               spi_mosi_o,
    output logic               spi_cs_n_o
);
    localparam int unsigned DW = $clog2(SPI_DIV + 1);

    logic [39:0]   shreg_q;   // command byte, then parameters
    logic [DW-1:0] div_q;
    logic [2:0]    bit_q;
    logic [2:0]    byte_q;    // bytes left after the current one
    logic          sck_q;
    logic          busy_q;
    logic          tick;
    logic [2:0]    nbytes;

    assign tick   = busy_q && (div_q == DW'(SPI_DIV - 1));
    assign nbytes = (cmd_i.counter > 4'd4) ? 3'd4 : cmd_i.counter[2:0];  // clamp to 4

    assign busy_o     = busy_q;
    assign spi_sck_o  = sck_q;
    assign spi_mosi_o = shreg_q[39];
    assign spi_cs_n_o = ~busy_q;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            shreg_q <= '0;
            div_q   <= '0;
            bit_q   <= '0;
            byte_q  <= '0;
            sck_q   <= 1'b0;
            busy_q  <= 1'b0;
        end else if (!busy_q) begin
            if (cmd_i.start) begin
                shreg_q <= {cmd_i.command, cmd_i.parameters};
                byte_q  <= nbytes;
                bit_q   <= '0;
                div_q   <= '0;
                sck_q   <= 1'b0;
                busy_q  <= 1'b1;  // cs_n goes low with it
            end
        end else if (!tick) begin
            div_q <= div_q + 1'b1;
        end else begin
            div_q <= '0;
            if (!sck_q) begin
                sck_q <= 1'b1;   // rising edge, device samples here
            end else begin
                sck_q   <= 1'b0;
                shreg_q <= {shreg_q[38:0], 1'b0};  // next bit on the falling edge
                if (bit_q == 3'd7) begin
                    bit_q <= '0;
                    if (byte_q == '0) begin
                        busy_q <= 1'b0;  // frame done, cs_n rises
                    end else begin
                        byte_q <= byte_q - 1'b1;
                    end
                end else begin
                    bit_q <= bit_q + 1'b1;
                end
            end
        end
    end

endmodule

/* source/mmio.sv */
`timescale 1ns/10ps

module mmio #(
    parameter int unsigned MEM_BYTES = 2048
) (
    input  logic               clk,
    input  logic               nRst,
    // memory handler side
    input  mmio_pkg::mh_req_t  mh_req_i,
    output logic [31:0]        mh_data_o,
    output logic               mmio_busy_o,
    // data memory
    output mmio_pkg::mem_req_t mem_req_o,
    input  logic [31:0]        mem_data_i,
    input  logic               mem_busy_i,
    // display spi
    output mmio_pkg::spi_cmd_t spi_cmd_o,
    input  logic               spi_busy_i,
    // touch sample
    input  logic [31:0]        touch_xy_i,
    input  logic               touch_done_i,
    output logic               touch_clear_o
);
    import mmio_pkg::*;

    mmio_state_t state_q, state_d;
    mh_req_t     pend_q, pend_d;    // latched command
    mem_req_t    mem_q, mem_d;
    spi_cmd_t    spi_q, spi_d;
    logic [31:0] data_q, data_d;    // read data back to the handler
    logic        clear_q, clear_d;

    logic        rd_cmd;
    logic        wr_cmd;
    logic        hit_mem;
    logic        hit_i2c;
    logic        hit_spi_cmd;
    logic        hit_spi_par;

    // decode works on the latched command, not the live request
    assign rd_cmd      = pend_q.read | pend_q.getinst;
    assign wr_cmd      = pend_q.write;
    assign hit_i2c     = (pend_q.address == I2C_ADDR);
    assign hit_spi_cmd = (pend_q.address == SPI_ADDR_CMD);
    assign hit_spi_par = (pend_q.address == SPI_ADDR_PARAM);
    assign hit_mem     = (pend_q.address < 32'(MEM_BYTES));

    assign mmio_busy_o   = (state_q != IDLE);
    assign mh_data_o     = data_q;
    assign mem_req_o     = mem_q;
    assign spi_cmd_o     = spi_q;
    assign touch_clear_o = clear_q;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state_q <= IDLE;
            pend_q  <= '0;
            mem_q   <= '0;
            spi_q   <= '0;
            data_q  <= '0;
            clear_q <= 1'b0;
        end else begin
            state_q <= state_d;
            pend_q  <= pend_d;
            mem_q   <= mem_d;
            spi_q   <= spi_d;
            data_q  <= data_d;
            clear_q <= clear_d;
        end
    end

    always_comb begin
        state_d       = state_q;
        pend_d        = pend_q;
        mem_d         = mem_q;
        spi_d         = spi_q;
        spi_d.start   = 1'b0;  // start is a single pulse
        data_d        = data_q;
        clear_d       = 1'b0;

        case (state_q)
            IDLE: begin
                if (mh_req_i.read || mh_req_i.write || mh_req_i.getinst) begin
                    pend_d  = mh_req_i;
                    state_d = PENDING;
                end
            end

            PENDING: begin
                if (rd_cmd) begin
                    if (hit_i2c) begin
                        // no sample yet, keep waiting
                        if (touch_done_i) begin
                            data_d  = touch_xy_i;
                            clear_d = 1'b1;
                            state_d = DONE;
                        end
                    end else if (hit_mem) begin
                        if (!mem_busy_i) begin
                            mem_d.address = pend_q.address;
                            mem_d.read    = 1'b1;
                            state_d       = MEMREAD;
                        end
                    end else begin
                        data_d  = '0;  // unmapped read
                        state_d = DONE;
                    end
                end else if (wr_cmd) begin
                    if (hit_spi_cmd) begin
                        spi_d.command = pend_q.data[7:0];
                        spi_d.counter = pend_q.data[11:8];
                        state_d       = DONE;
                    end else if (hit_spi_par) begin
                        if (!spi_busy_i) begin  // hold off until the last frame ends
                            spi_d.parameters = pend_q.data;
                            spi_d.start      = 1'b1;
                            state_d          = DONE;
                        end
                    end else if (hit_mem) begin
                        if (!mem_busy_i) begin
                            mem_d.address = pend_q.address;
                            mem_d.data    = pend_q.data;
                            mem_d.write   = 1'b1;
                            state_d       = MEMWRITE;
                        end
                    end else begin
                        state_d = DONE;  // write dropped
                    end
                end else begin
                    state_d = DONE;
                end
            end

            MEMREAD: begin
                if (!mem_busy_i) begin
                    data_d     = mem_data_i;
                    mem_d.read = 1'b0;
                    state_d    = DONE;
                end
            end

            MEMWRITE: begin
                if (!mem_busy_i) begin
                    mem_d.write = 1'b0;
                    state_d     = DONE;
                end
            end

            DONE: state_d = IDLE;  // busy drops on the way back

            default: state_d = IDLE;
        endcase
    end

endmodule

/* source/mmio_top.sv */
`timescale 1ns/10ps

module mmio_top #(
    parameter int unsigned MEM_BYTES = 2048,
    parameter int unsigned MEM_WAIT  = 2,
    parameter int unsigned SPI_DIV   = 4
) (
    input  logic              clk,
    input  logic              nRst,
    input  mmio_pkg::mh_req_t mh_req_i,
    output logic [31:0]       mh_data_o,
    output logic              mmio_busy_o,
    input  logic [31:0]       i2c_xy_i,
    input  logic              i2c_valid_i,
    output logic              touch_done_o,
    output logic              spi_sck_o,
    output logic              spi_mosi_o,
    output logic              spi_cs_n_o
);
    import mmio_pkg::*;

    mem_req_t    mem_req;
    logic [31:0] mem_data;
    logic        mem_busy;
    spi_cmd_t    spi_cmd;
    logic        spi_busy;
    logic [31:0] touch_xy;
    logic        touch_clear;

    mmio #(
        .MEM_BYTES(MEM_BYTES)
    ) mmio_i (
        .clk          (clk),
        .nRst         (nRst),
        .mh_req_i     (mh_req_i),
        .mh_data_o    (mh_data_o),
        .mmio_busy_o  (mmio_busy_o),
        .mem_req_o    (mem_req),
        .mem_data_i   (mem_data),
        .mem_busy_i   (mem_busy),
        .spi_cmd_o    (spi_cmd),
        .spi_busy_i   (spi_busy),
        .touch_xy_i   (touch_xy),
        .touch_done_i (touch_done_o),
        .touch_clear_o(touch_clear)
    );

    wb_sram #(
        .MEM_BYTES(MEM_BYTES),
        .MEM_WAIT (MEM_WAIT)
    ) wb_sram_i (
        .clk   (clk),
        .nRst  (nRst),
        .req_i (mem_req),
        .data_o(mem_data),
        .busy_o(mem_busy)
    );

    spi_cmd_shifter #(
        .SPI_DIV(SPI_DIV)
    ) spi_cmd_shifter_i (
        .clk       (clk),
        .nRst      (nRst),
        .cmd_i     (spi_cmd),
        .busy_o    (spi_busy),
        .spi_sck_o (spi_sck_o),
        .spi_mosi_o(spi_mosi_o),
        .spi_cs_n_o(spi_cs_n_o)
    );

    touch_latch touch_latch_i (
        .clk        (clk),
        .nRst       (nRst),
        .i2c_xy_i   (i2c_xy_i),
        .i2c_valid_i(i2c_valid_i),
        .clear_i    (touch_clear),
        .xy_o       (touch_xy),
        .done_o     (touch_done_o)
    );

endmodule

/* bench/mmio_tb.sv */
`timescale 1ns/10ps

module mmio_tb;
    import mmio_pkg::*;

    localparam int unsigned MEM_BYTES = 2048;
    localparam int unsigned MEM_WAIT  = 2;
    localparam int unsigned SPI_DIV   = 4;
    localparam int          TIMEOUT   = 4000;  // clk cycles allowed per wait

    logic        clk;
    logic        nRst;
    mh_req_t     mh_req;
    logic [31:0] mh_data;
    logic        mmio_busy;
    logic [31:0] i2c_xy;
    logic        i2c_valid;
    logic        touch_done;
    logic        spi_sck;
    logic        spi_mosi;
    logic        spi_cs_n;

    int mismatch_count;
    int fail_count;
    int seed;

    mmio_top #(
        .MEM_BYTES(MEM_BYTES),
        .MEM_WAIT (MEM_WAIT),
        .SPI_DIV  (SPI_DIV)
    ) mmio_top_i (
        .clk         (clk),
        .nRst        (nRst),
        .mh_req_i    (mh_req),
        .mh_data_o   (mh_data),
        .mmio_busy_o (mmio_busy),
        .i2c_xy_i    (i2c_xy),
        .i2c_valid_i (i2c_valid),
        .touch_done_o(touch_done),
        .spi_sck_o   (spi_sck),
        .spi_mosi_o  (spi_mosi),
        .spi_cs_n_o  (spi_cs_n)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            mismatch_count++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            mismatch_count++;
            $display("Mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_spi(input string name, input spi_cmd_t exp, input spi_cmd_t act);
        if (act !== exp) begin
            mismatch_count++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // one-cycle request, then count the cycles busy stays high
    task automatic issue_cmd(input string name, input mh_req_t req, output int busy_cycles);
        int n;
        n = 0;
        @(posedge clk);
        #1;
        mh_req = req;
        @(posedge clk);
        #1;
        mh_req = '0;
        while (mmio_busy && n < TIMEOUT) begin
            n++;
            @(posedge clk);
            #1;
        end
        if (mmio_busy) begin
            fail_count++;
            $display("%s: mmio_busy_o still high after %0d cycles", name, TIMEOUT);
        end
        busy_cycles = n;
    endtask

    task automatic write_word(input string name, input logic [31:0] addr,
                              input logic [31:0] data, output int cycles);
        mh_req_t req;
        req         = '0;
        req.write   = 1'b1;
        req.address = addr;
        req.data    = data;
        issue_cmd(name, req, cycles);
    endtask

    task automatic read_word(input string name, input logic [31:0] addr, input logic fetch,
                             output logic [31:0] data, output int cycles);
        mh_req_t req;
        req         = '0;
        req.read    = ~fetch;
        req.getinst = fetch;
        req.address = addr;
        issue_cmd(name, req, cycles);
        data = mh_data;  // holds until the next read
    endtask

    // bits come in right aligned and low_cycles counts clk cycles with cs_n low
    task automatic spi_capture(input string name, output logic [39:0] bits,
                               output int nbits, output int low_cycles);
        int   n;
        logic sck_prev;
        bits       = '0;
        nbits      = 0;
        low_cycles = 0;
        n          = 0;
        sck_prev   = 1'b0;
        while (spi_cs_n && n < TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        if (spi_cs_n) begin
            fail_count++;
            $display("%s: chip select never went low", name);
        end else begin
            while (!spi_cs_n && low_cycles < TIMEOUT) begin
                if (spi_sck && !sck_prev && nbits < 40) begin  // mode 0 sample point
                    bits = {bits[38:0], spi_mosi};
                    nbits++;
                end
                sck_prev = spi_sck;
                low_cycles++;
                @(negedge clk);
            end
            if (!spi_cs_n) begin
                fail_count++;
                $display("%s: chip select stuck low", name);
            end
        end
    endtask

    // frame seen on the pins, put back into command form
    task automatic check_frame(input string name, input logic [7:0] cmd, input logic [3:0] cnt,
                               input logic [31:0] par, input logic [39:0] bits,
                               input int nbits, input int low_cycles);
        spi_cmd_t    exp;
        spi_cmd_t    got;
        logic [39:0] aligned;
        aligned        = bits << (40 - nbits);
        got            = '0;
        got.command    = aligned[39:32];
        got.counter    = 4'(nbits / 8 - 1);
        got.parameters = aligned[31:0];
        exp            = '0;
        exp.command    = cmd;
        exp.counter    = cnt;
        exp.parameters = par & ~(32'hffff_ffff >> (8 * cnt));  // only sent bytes survive
        check_word({name, " bit count"}, 32'(8 * (cnt + 1)), 32'(nbits));
        check_word({name, " frame length"}, 32'(2 * SPI_DIV * 8 * (cnt + 1)), 32'(low_cycles));
        check_spi(name, exp, got);
    endtask

    task automatic reset_values();
        check_flag("reset busy", 1'b0, mmio_busy);
        check_flag("reset cs_n", 1'b1, spi_cs_n);
        check_flag("reset sck", 1'b0, spi_sck);
        check_flag("reset touch done", 1'b0, touch_done);
    endtask

    task automatic memory_roundtrip();
        logic [31:0] addrs [6];
        logic [31:0] words [6];
        logic [31:0] got;
        int          cycles;
        addrs[0] = 32'h0;
        addrs[1] = 32'h4;
        addrs[2] = 32'h100;
        addrs[3] = 32'h3fc;
        addrs[4] = 32'h7fc;  // last word of the window
        addrs[5] = ($random(seed) & 32'h3f8) | 32'h400;
        for (int i = 0; i < 6; i++) begin
            words[i] = $random(seed);
            write_word("mem write", addrs[i], words[i], cycles);
        end
        for (int i = 0; i < 6; i++) begin
            read_word("mem read", addrs[i], 1'b0, got, cycles);
            check_word("mem read", words[i], got);
        end
        // each fetch follows an access to a different word
        for (int i = 0; i < 6; i++) begin
            read_word("mem fetch", addrs[i], 1'b1, got, cycles);
            check_word("mem fetch", words[i], got);
        end
    endtask

    task automatic spi_frame(input string name, input logic [7:0] cmd, input logic [3:0] cnt);
        logic [31:0] par;
        logic [39:0] bits;
        int          nbits;
        int          len;
        int          cycles;
        par = $random(seed);
        write_word({name, " cmd"}, SPI_ADDR_CMD, {20'd0, cnt, cmd}, cycles);
        check_word({name, " cmd busy"}, 32'd2, 32'(cycles));
        fork
            spi_capture(name, bits, nbits, len);
            begin
                write_word({name, " param"}, SPI_ADDR_PARAM, par, cycles);
                check_word({name, " param busy"}, 32'd2, 32'(cycles));
            end
        join
        check_frame(name, cmd, cnt, par, bits, nbits, len);
    endtask

    task automatic spi_backpressure();
        logic [31:0] par1;
        logic [31:0] par2;
        logic [39:0] bits1;
        logic [39:0] bits2;
        int          n1;
        int          n2;
        int          len1;
        int          len2;
        int          cycles;
        logic        first_done;
        par1       = $random(seed);
        par2       = $random(seed);
        first_done = 1'b0;
        write_word("bp cmd", SPI_ADDR_CMD, {20'd0, 4'd4, 8'h2c}, cycles);
        fork
            begin
                spi_capture("bp frame 1", bits1, n1, len1);
                first_done = 1'b1;
                spi_capture("bp frame 2", bits2, n2, len2);
            end
            begin
                write_word("bp param 1", SPI_ADDR_PARAM, par1, cycles);
                write_word("bp param 2", SPI_ADDR_PARAM, par2, cycles);  // shifter still busy
                if (!first_done) begin
                    fail_count++;
                    $display("bp: second parameter write finished before the first frame ended");
                end
            end
        join
        check_frame("bp frame 1", 8'h2c, 4'd4, par1, bits1, n1, len1);
        check_frame("bp frame 2", 8'h2c, 4'd4, par2, bits2, n2, len2);
    endtask

    task automatic touch_read();
        logic [31:0] xy;
        logic [31:0] got;
        int          cycles;
        xy = $random(seed);
        @(posedge clk);
        #1;
        i2c_xy    = xy;
        i2c_valid = 1'b1;
        @(posedge clk);
        #1;
        i2c_valid = 1'b0;
        check_flag("touch done set", 1'b1, touch_done);
        read_word("touch read", I2C_ADDR, 1'b0, got, cycles);
        check_word("touch xy", xy, got);
        check_word("touch busy", 32'd2, 32'(cycles));
        check_flag("touch done cleared", 1'b0, touch_done);
    endtask

    task automatic unmapped_access();
        logic [31:0] got;
        int          cycles;
        read_word("unmapped read", 32'h0001_0000, 1'b0, got, cycles);
        check_word("unmapped data", 32'h0, got);
        check_word("unmapped busy", 32'd2, 32'(cycles));
    endtask

    initial begin
        seed           = 53007;
        mismatch_count = 0;
        fail_count     = 0;
        nRst           = 1'b0;
        mh_req         = '0;
        i2c_xy         = '0;
        i2c_valid      = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        nRst = 1'b1;
        reset_values();
        memory_roundtrip();
        spi_frame("spi count 0", 8'h2a, 4'd0);
        spi_frame("spi count 4", 8'hb6, 4'd4);
        spi_backpressure();
        touch_read();
        unmapped_access();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
source/mmio_pkg.sv
source/touch_latch.sv
source/wb_sram.sv
source/spi_cmd_shifter.sv
source/mmio.sv
source/mmio_top.sv
bench/mmio_tb.sv

/* Makefile */
BIN = obj_dir/Vmmio_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module mmio_tb -Mdir obj_dir -f flist.f

# pass only if the status line shows up in the output
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
